// ==== design/ctmm_pkg.sv ====
// Shared CTMM types. Only the 64-bit GT word is modelled, and perms must sit at bits 57:48
package ctmm_pkg;

    // ==================================================
    // Golden token word
    // ==================================================

    typedef struct packed {
        logic [5:0]  version;  // Bits 63:58
        logic [9:0]  perms;    // Bits 57:48
        logic [7:0]  limit;    // Number of slots
        logic [39:0] base;     // Byte address of slot 0
    } gt_fields_t;

    // One 64-bit word, read as memory data or as GT fields
    typedef union packed {
        logic [63:0] raw;
        gt_fields_t  gt;
    } gt_word_u;

    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_PERM_L = 2'd1,  // Source lacks load permission
        FAULT_PERM_S = 2'd2,  // Thread lacks save permission
        FAULT_BOUNDS = 2'd3   // Slot index at or past limit
    } fault_type_t;

    // ==================================================
    // Permission bits and register numbers
    // ==================================================

    localparam int PERM_L = 2;  // Position within perms
    localparam int PERM_S = 1;

    // CR7 nucleus, CR8 thread, CR15 namespace
    localparam logic [15:0] RESERVED_MASK = 16'b1000_0001_1000_0000;

    localparam logic [3:0] CR_THREAD = 4'd8;   // Holds the thread capability
    localparam logic [3:0] LAST_CR   = 4'd14;  // Highest register visited by the loops

endpackage

// ==== design/slot_walker.sv ====
// Visits selected CRs in ascending order; reserved registers never come out, cur_idx lags by one
module slot_walker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        step,     // Advance to the next selected register
    input  logic        restart,  // Rewind to the first selected register
    input  logic [15:0] mask,
    output logic [3:0]  cur_idx,
    output logic        last      // Walk exhausted, no register at cur_idx
);
    import ctmm_pkg::*;

    logic [15:0] eff_mask;
    logic [3:0]  first_idx;
    logic [3:0]  next_idx;
    logic        first_ok;
    logic        next_ok;
    logic        valid_q;

    assign eff_mask = mask & ~RESERVED_MASK;  // CR7, CR8, CR15 dropped

    // Downward scan, so the lowest matching register wins
    always_comb begin
        first_idx = '0;
        first_ok  = 1'b0;
        next_idx  = '0;
        next_ok   = 1'b0;
        for (int i = int'(LAST_CR); i >= 0; i--) begin
            if (eff_mask[i]) begin
                first_idx = 4'(i);
                first_ok  = 1'b1;
                if (4'(i) > cur_idx) begin  // Strictly after the current one
                    next_idx = 4'(i);
                    next_ok  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_idx <= '0;
            valid_q <= 1'b0;
        end else if (restart) begin
            cur_idx <= first_idx;
            valid_q <= first_ok;  // Empty mask ends the walk at once
        end else if (step) begin
            cur_idx <= next_idx;
            valid_q <= next_ok;
        end
    end

    assign last = !valid_q;

endmodule

// ==== design/msave_unit.sv ====
// Saves one GT word into the thread slot table; request held until mem_wr_done, address cut to ADDR_W
module msave_unit #(
    parameter int ADDR_W = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  save_start,
    input  ctmm_pkg::gt_word_u    thread_cap,  // CR8, owner of the slot table
    input  ctmm_pkg::gt_word_u    src_gt,      // Word to store
    input  logic [3:0]            slot,
    input  logic                  mem_wr_done,
    output logic                  save_done,
    output logic                  save_fault,
    output ctmm_pkg::fault_type_t save_fault_type,
    output logic [ADDR_W-1:0]     mem_wr_addr,
    output logic [63:0]           mem_wr_data,
    output logic                  mem_wr_en
);
    import ctmm_pkg::*;

    typedef enum logic [1:0] {
        SV_IDLE,
        SV_CHECK,  // Cycle after start
        SV_WRITE,  // Waiting for acknowledge
        SV_DONE
    } sv_state_t;

    sv_state_t   state;
    gt_word_u    cap_q;
    gt_word_u    src_q;
    logic [3:0]  slot_q;
    logic        perm_ok;
    logic        bounds_ok;
    logic        check_ok;
    logic [63:0] slot_addr;

    // Operands held for the whole save
    always_ff @(posedge clk) begin
        if (save_start) begin
            cap_q  <= thread_cap;
            src_q  <= src_gt;
            slot_q <= slot;
        end
    end

    assign perm_ok   = cap_q.gt.perms[PERM_S];
    assign bounds_ok = {4'd0, slot_q} < cap_q.gt.limit;
    assign check_ok  = perm_ok && bounds_ok;

    // Permission outranks bounds
    assign save_fault_type = !perm_ok   ? FAULT_PERM_S :
                             !bounds_ok ? FAULT_BOUNDS : FAULT_NONE;
    assign save_fault      = (state == SV_CHECK) && !check_ok;

    assign slot_addr   = 64'(cap_q.gt.base) + {57'd0, slot_q, 3'b000};  // base + 8*slot
    assign mem_wr_addr = slot_addr[ADDR_W-1:0];
    assign mem_wr_data = src_q.raw;
    assign mem_wr_en   = (state == SV_CHECK && check_ok) || state == SV_WRITE;
    assign save_done   = (state == SV_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SV_IDLE;
        end else begin
            case (state)
                SV_IDLE: if (save_start) state <= SV_CHECK;
                SV_CHECK: begin
                    if (!check_ok) state <= SV_IDLE;           // Fault pulsed this cycle
                    else if (mem_wr_done) state <= SV_DONE;    // Zero-delay acknowledge
                    else state <= SV_WRITE;
                end
                SV_WRITE: if (mem_wr_done) state <= SV_DONE;
                default: state <= SV_IDLE;
            endcase
        end
    end

endmodule

// ==== design/mload_unit.sv ====
// Loads one slot word into a CR; source read on a combinational port, address cut to ADDR_W
module mload_unit #(
    parameter int ADDR_W = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_start,
    input  logic [3:0]            load_src,    // C-List register to read through
    input  logic [3:0]            load_dst,
    input  logic [7:0]            load_index,
    input  ctmm_pkg::gt_word_u    cr_rd_data,
    input  logic [63:0]           mem_rd_data,
    input  logic                  mem_rd_valid,
    output logic                  load_done,
    output logic                  load_fault,
    output ctmm_pkg::fault_type_t load_fault_type,
    output logic [3:0]            cr_rd_addr,
    output logic [3:0]            cr_wr_addr,
    output ctmm_pkg::gt_word_u    cr_wr_data,
    output logic                  cr_wr_en,
    output logic [ADDR_W-1:0]     mem_rd_addr,
    output logic                  mem_rd_en
);
    import ctmm_pkg::*;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_CHECK,  // Source read and checked
        LD_READ,   // Waiting for read data
        LD_WRITE   // Register write and done
    } ld_state_t;

    ld_state_t   state;
    logic [3:0]  src_q;
    logic [3:0]  dst_q;
    logic [7:0]  index_q;
    gt_word_u    cap_q;
    gt_word_u    cap_w;
    gt_word_u    data_q;
    logic        perm_ok;
    logic        bounds_ok;
    logic        check_ok;
    logic [63:0] slot_addr;

    always_ff @(posedge clk) begin
        if (load_start) begin
            src_q   <= load_src;
            dst_q   <= load_dst;
            index_q <= load_index;
        end
        if (state == LD_CHECK) cap_q <= cr_rd_data;                    // Keeps base steady
        if (mem_rd_en && mem_rd_valid) data_q.raw <= mem_rd_data;
    end

    assign cr_rd_addr = src_q;

    // Live read port in the check cycle, latched copy afterwards
    assign cap_w = (state == LD_CHECK) ? cr_rd_data : cap_q;

    // ==================================================
    // Source checks, L before bounds
    // ==================================================

    assign perm_ok   = cap_w.gt.perms[PERM_L];
    assign bounds_ok = index_q < cap_w.gt.limit;
    assign check_ok  = perm_ok && bounds_ok;

    assign load_fault_type = !perm_ok   ? FAULT_PERM_L :
                             !bounds_ok ? FAULT_BOUNDS : FAULT_NONE;
    assign load_fault      = (state == LD_CHECK) && !check_ok;

    assign slot_addr   = 64'(cap_w.gt.base) + {53'd0, index_q, 3'b000};  // base + 8*index
    assign mem_rd_addr = slot_addr[ADDR_W-1:0];
    assign mem_rd_en   = (state == LD_CHECK && check_ok) || state == LD_READ;

    assign cr_wr_addr = dst_q;
    assign cr_wr_data = data_q;
    assign cr_wr_en   = (state == LD_WRITE);  // Single-cycle write
    assign load_done  = (state == LD_WRITE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: if (load_start) state <= LD_CHECK;
                LD_CHECK: begin
                    if (!check_ok) state <= LD_IDLE;
                    else if (mem_rd_valid) state <= LD_WRITE;
                    else state <= LD_READ;
                end
                LD_READ: if (mem_rd_valid) state <= LD_WRITE;
                default: state <= LD_IDLE;
            endcase
        end
    end

endmodule

// ==== design/change_seq.sv ====
// CHANGE controller; one unit call at a time, first fault ends the run, fault_type held to next start
module change_seq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  change_start,
    input  logic [3:0]            cr_src,
    input  logic [7:0]            index,
    input  logic [15:0]           change_mask,
    input  ctmm_pkg::gt_word_u    cr_rd_data,
    input  logic [3:0]            load_rd_addr,  // Read address wanted by the load unit
    input  logic [3:0]            cur_idx,
    input  logic                  last,
    input  logic                  save_done,
    input  logic                  save_fault,
    input  ctmm_pkg::fault_type_t save_fault_type,
    input  logic                  load_done,
    input  logic                  load_fault,
    input  ctmm_pkg::fault_type_t load_fault_type,
    output logic                  change_busy,
    output logic                  change_complete,
    output logic                  change_fault,
    output ctmm_pkg::fault_type_t fault_type,
    output logic [3:0]            cr_rd_addr,
    output ctmm_pkg::gt_word_u    saved_gt,
    output logic                  step,
    output logic                  restart,
    output logic [15:0]           walk_mask,
    output logic                  save_start,
    output logic                  load_start,
    output logic [3:0]            load_src,
    output logic [3:0]            load_dst,
    output logic [7:0]            load_index
);
    import ctmm_pkg::*;

    typedef enum logic [3:0] {
        CH_IDLE,
        CH_CHECK,      // CRn L check
        CH_SAVE_SEL,   // Pick next register to save, or go load
        CH_SAVE_GO,
        CH_SAVE_WAIT,
        CH_LOAD_WAIT,  // New thread GT into CR8
        CH_REST_SEL,
        CH_REST_WAIT,
        CH_DONE,
        CH_FAULT
    } ch_state_t;

    ch_state_t  state;
    logic [3:0] src_q;
    logic [7:0] index_q;
    logic [15:0] mask_q;
    logic       crn_l_ok;
    logic       restoring;

    always_ff @(posedge clk) begin
        if (state == CH_IDLE && change_start) begin
            src_q   <= cr_src;
            index_q <= index;
            mask_q  <= change_mask;
        end
        if (state == CH_SAVE_SEL && !last) saved_gt <= cr_rd_data;  // GT of the register to save
    end

    assign crn_l_ok  = cr_rd_data.gt.perms[PERM_L];
    assign walk_mask = mask_q;
    assign restoring = (state == CH_REST_SEL) || (state == CH_REST_WAIT);

    // ==================================================
    // Register read port ownership
    // ==================================================

    always_comb begin
        case (state)
            CH_IDLE:     cr_rd_addr = cr_src;
            CH_CHECK:    cr_rd_addr = src_q;
            CH_SAVE_SEL: cr_rd_addr = cur_idx;
            default:     cr_rd_addr = load_rd_addr;  // Load unit owns it from here
        endcase
    end

    // ==================================================
    // Walker and unit controls
    // ==================================================

    assign restart    = (state == CH_CHECK && crn_l_ok) || (state == CH_LOAD_WAIT && load_done);
    assign step       = (state == CH_SAVE_WAIT && save_done) || (state == CH_REST_WAIT && load_done);
    assign save_start = (state == CH_SAVE_GO);  // saved_gt already stable here
    assign load_start = (state == CH_SAVE_SEL && last) || (state == CH_REST_SEL && !last);

    // Load phase CRn[index] -> CR8, restore phase CR8[i] -> CRi
    assign load_src   = restoring ? CR_THREAD : src_q;
    assign load_dst   = restoring ? cur_idx : CR_THREAD;
    assign load_index = restoring ? {4'd0, cur_idx} : index_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CH_IDLE;
            fault_type <= FAULT_NONE;
        end else begin
            case (state)
                CH_IDLE: begin
                    if (change_start) begin
                        state      <= CH_CHECK;
                        fault_type <= FAULT_NONE;  // Old fault dropped on new start
                    end
                end
                CH_CHECK: begin
                    if (crn_l_ok) begin
                        state <= CH_SAVE_SEL;
                    end else begin
                        state      <= CH_FAULT;
                        fault_type <= FAULT_PERM_L;
                    end
                end
                CH_SAVE_SEL: state <= last ? CH_LOAD_WAIT : CH_SAVE_GO;
                CH_SAVE_GO:  state <= CH_SAVE_WAIT;
                CH_SAVE_WAIT: begin
                    if (save_fault) begin
                        state      <= CH_FAULT;
                        fault_type <= save_fault_type;
                    end else if (save_done) begin
                        state <= CH_SAVE_SEL;
                    end
                end
                CH_LOAD_WAIT, CH_REST_WAIT: begin
                    if (load_fault) begin
                        state      <= CH_FAULT;
                        fault_type <= load_fault_type;
                    end else if (load_done) begin
                        state <= CH_REST_SEL;
                    end
                end
                CH_REST_SEL: state <= last ? CH_DONE : CH_REST_WAIT;
                default:     state <= CH_IDLE;  // One end pulse, then idle
            endcase
        end
    end

    assign change_busy     = (state != CH_IDLE);
    assign change_complete = (state == CH_DONE);
    assign change_fault    = (state == CH_FAULT);

endmodule

// ==== design/ctmm_change.sv ====
// CHANGE top level; memory and register file are external, single request in flight
module ctmm_change #(
    parameter int ADDR_W = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  change_start,
    input  logic [3:0]            cr_src,
    input  logic [7:0]            index,
    input  logic [15:0]           change_mask,
    output logic                  change_busy,
    output logic                  change_complete,
    output logic                  change_fault,
    output ctmm_pkg::fault_type_t fault_type,
    output logic [3:0]            cr_rd_addr,
    input  ctmm_pkg::gt_word_u    cr_rd_data,
    output logic [3:0]            cr_wr_addr,
    output ctmm_pkg::gt_word_u    cr_wr_data,
    output logic                  cr_wr_en,
    input  ctmm_pkg::gt_word_u    cr8_thread,  // Current thread capability
    output logic [ADDR_W-1:0]     mem_rd_addr,
    output logic                  mem_rd_en,
    input  logic [63:0]           mem_rd_data,
    input  logic                  mem_rd_valid,
    output logic [ADDR_W-1:0]     mem_wr_addr,
    output logic [63:0]           mem_wr_data,
    output logic                  mem_wr_en,
    input  logic                  mem_wr_done
);
    import ctmm_pkg::*;

    logic        step, restart, last;
    logic [3:0]  cur_idx;
    logic [15:0] walk_mask;
    gt_word_u    saved_gt;
    logic        save_start, save_done, save_fault;
    fault_type_t save_fault_type;
    logic        load_start, load_done, load_fault;
    fault_type_t load_fault_type;
    logic [3:0]  load_src, load_dst;
    logic [7:0]  load_index;
    logic [3:0]  load_rd_addr;

    change_seq u_seq (
        .clk, .rst_n, .change_start, .cr_src, .index, .change_mask, .cr_rd_data,
        .load_rd_addr, .cur_idx, .last, .save_done, .save_fault, .save_fault_type,
        .load_done, .load_fault, .load_fault_type, .change_busy, .change_complete,
        .change_fault, .fault_type, .cr_rd_addr, .saved_gt, .step, .restart, .walk_mask,
        .save_start, .load_start, .load_src, .load_dst, .load_index
    );

    slot_walker u_walker (
        .clk, .rst_n, .step, .restart, .mask(walk_mask), .cur_idx, .last
    );

    // Slot number equals the register number being saved
    msave_unit #(.ADDR_W(ADDR_W)) u_msave (
        .clk, .rst_n, .save_start, .thread_cap(cr8_thread), .src_gt(saved_gt),
        .slot(cur_idx), .mem_wr_done, .save_done, .save_fault, .save_fault_type,
        .mem_wr_addr, .mem_wr_data, .mem_wr_en
    );

    mload_unit #(.ADDR_W(ADDR_W)) u_mload (
        .clk, .rst_n, .load_start, .load_src, .load_dst, .load_index, .cr_rd_data,
        .mem_rd_data, .mem_rd_valid, .load_done, .load_fault, .load_fault_type,
        .cr_rd_addr(load_rd_addr), .cr_wr_addr, .cr_wr_data, .cr_wr_en,
        .mem_rd_addr, .mem_rd_en
    );

endmodule

// ==== bench/change_model.svh ====
// Reference model of CHANGE; assumes CRn is not CR8, untouched memory reads return fill_word
gt_word_u    exp_cr [16];              // Expected register file
logic [63:0] exp_mem [logic [63:0]];   // Expected sparse slot memory

// Background pattern, every address bit matters
function automatic logic [63:0] fill_word(input logic [63:0] addr);
    return addr ^ {addr[31:0], addr[63:32]} ^ 64'h5A5A_0F0F_C3C3_9696;
endfunction

function automatic logic [63:0] exp_word(input logic [63:0] addr);
    return exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr);
endfunction

function automatic logic [63:0] slot_address(input logic [39:0] base, input int slot);
    return 64'(base) + 64'(slot) * 64'd8;  // Eight bytes per slot
endfunction

// Applies save, load and restore to exp_cr and exp_mem; partial effects stay on a fault
function automatic fault_type_t predict_change(input logic [3:0] src, input logic [7:0] idx,
                                               input logic [15:0] mask);
    gt_word_u    crn;
    gt_word_u    thr;
    logic [15:0] sel;
    sel = mask & 16'h7E7F;  // CR7, CR8 and CR15 never take part
    crn = exp_cr[src];
    if (!crn.gt.perms[PERM_L]) return FAULT_PERM_L;
    // Save into the old thread's table
    thr = exp_cr[8];
    for (int i = 0; i < 16; i++) begin
        if (sel[i]) begin
            if (!thr.gt.perms[PERM_S]) return FAULT_PERM_S;
            if (i >= int'(thr.gt.limit)) return FAULT_BOUNDS;
            exp_mem[slot_address(thr.gt.base, i)] = exp_cr[i].raw;
        end
    end
    // New thread GT from CRn slot idx
    if (idx >= crn.gt.limit) return FAULT_BOUNDS;
    exp_cr[8].raw = exp_word(slot_address(crn.gt.base, int'(idx)));
    // Restore through the new CR8
    thr = exp_cr[8];
    for (int i = 0; i < 16; i++) begin
        if (sel[i]) begin
            if (!thr.gt.perms[PERM_L]) return FAULT_PERM_L;
            if (i >= int'(thr.gt.limit)) return FAULT_BOUNDS;
            exp_cr[i].raw = exp_word(slot_address(thr.gt.base, i));
        end
    end
    return FAULT_NONE;
endfunction

// ==== bench/change_tb.sv ====
// CHANGE testbench; memory acknowledges after 0 to 3 cycles, stops at the first mismatch
module change_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ctmm_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 5;
    localparam int    NUM_CHANGES  = 16;  // 1 + 8 + 1 + 1 + 1 + 4
    localparam longint WATCHDOG_NS = longint'(RESET_CYCLES + NUM_CHANGES * 400) * CLK_PERIOD;

    logic        clk, rst_n, change_start;
    logic [3:0]  cr_src;
    logic [7:0]  index;
    logic [15:0] change_mask;
    logic        change_busy, change_complete, change_fault;
    fault_type_t fault_type;
    logic [3:0]  cr_rd_addr, cr_wr_addr;
    gt_word_u    cr_rd_data, cr_wr_data, cr8_thread;
    logic        cr_wr_en;
    logic [63:0] mem_rd_addr, mem_wr_addr, mem_rd_data, mem_wr_data;
    logic        mem_rd_en, mem_rd_valid, mem_wr_en, mem_wr_done;

    gt_word_u    regs [16];              // Register file model
    logic [63:0] mem [logic [63:0]];     // Sparse slot memory
    logic [31:0] wr_seed, rd_seed, stim_seed;
    int          wr_wait, rd_wait;

    `include "change_model.svh"

    ctmm_change #(.ADDR_W(64)) u_ctmm_change (.*);

    // ==================================================
    // Clock, register file, memory
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign cr_rd_data = regs[cr_rd_addr];  // Combinational read port
    assign cr8_thread = regs[8];

    always @(posedge clk) begin
        if (cr_wr_en) regs[cr_wr_addr] <= cr_wr_data;
    end

    function automatic logic [31:0] xorshift(inout logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [63:0] mem_word(input logic [63:0] addr);
        return mem.exists(addr) ? mem[addr] : fill_word(addr);
    endfunction

    always @(negedge clk) begin  // Write acknowledge, one cycle wide
        if (mem_wr_done) begin
            mem_wr_done = 1'b0;
        end else if (mem_wr_en) begin
            if (wr_wait < 0) wr_wait = int'(xorshift(wr_seed) & 32'd3);
            if (wr_wait == 0) begin
                mem[mem_wr_addr] = mem_wr_data;
                mem_wr_done = 1'b1;
                wr_wait = -1;
            end else begin
                wr_wait--;
            end
        end
    end

    always @(negedge clk) begin  // Read data with valid
        if (mem_rd_valid) begin
            mem_rd_valid = 1'b0;
        end else if (mem_rd_en) begin
            if (rd_wait < 0) rd_wait = int'(xorshift(rd_seed) & 32'd3);
            if (rd_wait == 0) begin
                mem_rd_data  = mem_word(mem_rd_addr);
                mem_rd_valid = 1'b1;
                rd_wait = -1;
            end else begin
                rd_wait--;
            end
        end
    end

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic fail_now();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_gt(input string name, input gt_word_u exp, input gt_word_u act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_fault(input string name, input fault_type_t exp, input fault_type_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %s actual %s", $time, name,
                     exp.name(), act.name());
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
            fail_now();
        end
    endtask

    // Whole register file plus every memory word either side touched
    task automatic compare_state();
        foreach (exp_cr[i]) check_gt($sformatf("cr[%0d]", i), exp_cr[i], regs[i]);
        foreach (exp_mem[a]) check_gt($sformatf("mem[%h]", a), exp_mem[a], mem_word(a));
        foreach (mem[a]) check_gt($sformatf("mem[%h]", a), exp_word(a), mem[a]);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    function automatic logic [63:0] rnd64();
        return {xorshift(stim_seed), xorshift(stim_seed)};
    endfunction

    // Random registers, thread cap in CR8, CRn, and new thread GT in CRn slot idx
    task automatic prepare(input int tag, input logic [3:0] src, input logic [7:0] idx,
                           input logic [7:0] crn_limit, input bit crn_l, input bit thr_s);
        gt_word_u w;
        for (int i = 0; i < 16; i++) regs[i].raw = rnd64();
        w.raw = rnd64();
        w.gt.perms[PERM_S] = thr_s;
        w.gt.limit = 8'd16;
        w.gt.base  = 40'h1000 + 40'(tag) * 40'h400;
        regs[8] = w;
        w.raw = rnd64();
        w.gt.perms[PERM_L] = crn_l;
        w.gt.limit = crn_limit;
        w.gt.base  = 40'h80000 + 40'(tag) * 40'h800;
        regs[src] = w;
        w.raw = rnd64();
        w.gt.perms[PERM_L] = 1'b1;
        w.gt.limit = 8'd15;                         // Covers CR14
        w.gt.base  = 40'h40000 + 40'(tag) * 40'h400;
        mem[slot_address(regs[src].gt.base, int'(idx))] = w.raw;
    endtask

    task automatic run_change(input logic [3:0] src, input logic [7:0] idx,
                              input logic [15:0] mask, input bit poke);
        fault_type_t exp_f;
        exp_cr  = regs;
        exp_mem = mem;
        exp_f   = predict_change(src, idx, mask);
        cr_src = src;
        index = idx;
        change_mask = mask;
        change_start = 1'b1;
        @(negedge clk);
        change_start = 1'b0;
        check_bit("change_busy", 1'b1, change_busy);
        if (poke) begin  // Start while busy, must be ignored
            change_start = 1'b1;
            cr_src = ~src;
            index = ~idx;
            change_mask = ~mask;
        end
        @(negedge clk);
        change_start = 1'b0;
        while (!(change_complete || change_fault)) @(negedge clk);  // Wait for the end pulse
        check_bit("change_complete", exp_f == FAULT_NONE, change_complete);
        check_bit("change_fault", exp_f != FAULT_NONE, change_fault);
        if (exp_f != FAULT_NONE) check_fault("fault_type", exp_f, fault_type);
        @(negedge clk);
        check_bit("change_busy", 1'b0, change_busy);
        check_fault("fault_type", exp_f, fault_type);  // Held until next start
        compare_state();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: CHANGE sequence did not finish in the allowed time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [15:0] m;
        rst_n = 1'b0;
        change_start = 1'b0;
        cr_src = '0;
        index = '0;
        change_mask = '0;
        mem_rd_data = '0;
        mem_rd_valid = 1'b0;
        mem_wr_done = 1'b0;
        wr_wait = -1;
        rd_wait = -1;
        stim_seed = 32'd77;
        wr_seed = 32'd77 ^ 32'h1357_9BDF;   // Separate streams from one seed
        rd_seed = 32'd77 ^ 32'h2468_ACE0;
        for (int i = 0; i < 16; i++) regs[i].raw = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("change_busy", 1'b0, change_busy);
        check_bit("change_complete", 1'b0, change_complete);
        check_bit("change_fault", 1'b0, change_fault);
        check_bit("cr_wr_en", 1'b0, cr_wr_en);
        check_bit("mem_wr_en", 1'b0, mem_wr_en);
        check_bit("mem_rd_en", 1'b0, mem_rd_en);
        check_fault("fault_type", FAULT_NONE, fault_type);

        prepare(0, 4'd3, 8'd5, 8'd16, 1'b1, 1'b1);        // Full mask
        run_change(4'd3, 8'd5, 16'hFFFF, 1'b0);
        for (int t = 0; t < 8; t++) begin                 // Random masks, then empty ones
            m = 16'(xorshift(stim_seed));
            if (t == 6) m = 16'h8180;
            if (t == 7) m = 16'h0000;
            prepare(1 + t, 4'(t % 7), 8'(t * 2), 8'd16, 1'b1, 1'b1);
            run_change(4'(t % 7), 8'(t * 2), m, 1'b0);
        end
        prepare(9, 4'd10, 8'd1, 8'd16, 1'b0, 1'b1);       // CRn lacks L
        run_change(4'd10, 8'd1, 16'hFFFF, 1'b0);
        prepare(10, 4'd2, 8'd1, 8'd16, 1'b1, 1'b0);       // CR8 lacks S
        run_change(4'd2, 8'd1, 16'h00F0, 1'b0);
        prepare(11, 4'd5, 8'd4, 8'd4, 1'b1, 1'b1);        // Index at limit
        run_change(4'd5, 8'd4, 16'hFFFF, 1'b0);
        for (int t = 0; t < 4; t++) begin                 // Back to back with ignored starts
            m = 16'(xorshift(stim_seed));
            prepare(12 + t, 4'(9 + t), 8'(t + 3), 8'd16, 1'b1, 1'b1);
            run_change(4'(9 + t), 8'(t + 3), m, 1'b1);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+bench
design/ctmm_pkg.sv
design/slot_walker.sv
design/msave_unit.sv
design/mload_unit.sv
design/change_seq.sv
design/ctmm_change.sv
bench/change_tb.sv

// ==== Bender.yml ====
package:
  name: ctmm_change

sources:
  - files:
      - design/ctmm_pkg.sv
      - design/slot_walker.sv
      - design/msave_unit.sv
      - design/mload_unit.sv
      - design/change_seq.sv
      - design/ctmm_change.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/change_tb.sv
